/* src/pio_ctrl_pkg.sv */
package pio_ctrl_pkg;

  // Action codes the host side sends to the I/O core
  typedef enum logic [3:0] {
    act_none        = 4'd0,
    act_load_instr  = 4'd1,  // Data word into instruction memory at index
    act_set_pinctrl = 4'd5,  // SET base in 4:0, SET count in 7:5
    act_enable      = 4'd6,  // Bit 0 enables, pc restarts at 0
    act_exec        = 4'd9   // Low 16 bits executed immediately
  } pio_action_t;

  // One command per cycle that acts as a strobe when action is not none
  typedef struct packed {
    pio_action_t action;
    logic [4:0]  index;
    logic [31:0] data;
  } pio_cmd_t;

  // Program image depth in instruction words
  localparam int prog_depth = 32;

  // Entries in the configuration list
  localparam int conf_len = 3;

  // Blink half period as a power of two (about 0.17 s at 25 MHz)
  localparam int blink_period_log2 = 22;

endpackage

/* src/pio_isa_pkg.sv */
package pio_isa_pkg;

  // Only two opcodes are implemented
  typedef enum logic [2:0] {
    op_jmp = 3'd0,
    op_set = 3'd7
  } pio_opcode_t;

  // SET targets
  typedef enum logic [2:0] {
    dest_pins    = 3'd0,
    dest_pindirs = 3'd4
  } set_dest_t;

  // JMP view with the condition always treated as unconditional
  typedef struct packed {
    pio_opcode_t opcode;
    logic [4:0]  delay;
    logic [2:0]  condition;
    logic [4:0]  addr;
  } pio_jmp_t;

  // SET view
  typedef struct packed {
    pio_opcode_t opcode;
    logic [4:0]  delay;
    set_dest_t   dest;
    logic [4:0]  data;
  } pio_set_t;

  // One 16-bit instruction word, read through either view
  typedef union packed {
    pio_jmp_t jmp_f;
    pio_set_t set_f;
  } pio_instr_t;

  // Width of the pin output and direction registers
  localparam int num_pins = 32;

endpackage

/* src/pio_loader_fsm.sv */
`timescale 1ns/1ps

module pio_loader_fsm (
  input  logic                   clk_25mhz,
  input  logic                   pwr_up_reset_n,
  input  logic                   tick,
  output logic                   run,
  output pio_ctrl_pkg::pio_cmd_t cmd
);
  import pio_ctrl_pkg::*;
  import pio_isa_pkg::*;

  typedef enum logic [1:0] {
    st_load,
    st_conf,
    st_run
  } state_t;

  state_t      state;
  logic [15:0] prog_rom [prog_depth];
  logic [35:0] conf_rom [conf_len];  // Action in 35:32, data below
  logic [4:0]  pindex;
  logic [1:0]  cindex;
  logic        pin_val;              // Next value forced onto pin 0
  pio_instr_t  exec_word;

  initial begin
    $readmemh("blink.mem", prog_rom);
    $readmemh("exec_conf.mem", conf_rom);
  end

  // SET pins with the current blink value and no delay
  always_comb begin
    exec_word = '0;
    exec_word.set_f.opcode = op_set;
    exec_word.set_f.dest = dest_pins;
    exec_word.set_f.data = {4'b0000, pin_val};
  end

  always_ff @(posedge clk_25mhz) begin
    if (!pwr_up_reset_n) begin
      state <= st_load;
      pindex <= '0;
      cindex <= '0;
      run <= 1'b0;
      pin_val <= 1'b1;
      cmd.action <= act_none;
    end else begin
      case (state)
        st_load: begin
          // One program word per cycle
          cmd.action <= act_load_instr;
          cmd.index <= pindex;
          cmd.data <= {16'h0000, prog_rom[pindex]};
          pindex <= pindex + 1'b1;
          if (pindex == 5'(prog_depth - 1)) begin
            state <= st_conf;
          end
        end
        st_conf: begin
          if (cindex == 2'(conf_len)) begin
            cmd.action <= act_none;
            run <= 1'b1;
            state <= st_run;
          end else begin
            cmd.action <= pio_action_t'(conf_rom[cindex][35:32]);
            cmd.data <= conf_rom[cindex][31:0];
            cindex <= cindex + 1'b1;
          end
        end
        st_run: begin
          if (tick) begin
            cmd.action <= act_exec;
            cmd.data <= {16'h0000, exec_word};
            pin_val <= ~pin_val;  // Alternate 1, 0, 1
          end else begin
            cmd.action <= act_none;
          end
        end
        default: state <= st_load;
      endcase
    end
  end

endmodule

/* src/blink_timer.sv */
`timescale 1ns/1ps

module blink_timer #(
  parameter int period_log2 = pio_ctrl_pkg::blink_period_log2
) (
  input  logic clk_25mhz,
  input  logic pwr_up_reset_n,
  input  logic run,
  output logic tick
);

  logic [period_log2-1:0] count;

  // Held at zero until the loader reaches run state
  always_ff @(posedge clk_25mhz) begin
    if (!pwr_up_reset_n || !run) begin
      count <= '0;
    end else begin
      count <= count + 1'b1;  // Wraps at 2^period_log2
    end
  end

  // First run cycle and once per period after that
  assign tick = run && (count == '0);

endmodule

/* src/pio_core.sv */
`timescale 1ns/1ps

module pio_core (
  input  logic                             clk_25mhz,
  input  logic                             pwr_up_reset_n,
  input  pio_ctrl_pkg::pio_cmd_t           cmd,
  output logic [pio_isa_pkg::num_pins-1:0] gpio_out,
  output logic [pio_isa_pkg::num_pins-1:0] gpio_dir
);
  import pio_ctrl_pkg::*;
  import pio_isa_pkg::*;

  pio_instr_t          imem [prog_depth];
  logic [4:0]          pc;
  logic                enabled;
  logic [4:0]          set_base;
  logic [2:0]          set_count;

  logic                is_exec;
  logic                do_step;   // An instruction executes this cycle
  pio_instr_t          instr;
  logic [num_pins-1:0] set_mask;
  logic [num_pins-1:0] set_bits;

  // Instruction memory, written only by load commands
  always_ff @(posedge clk_25mhz) begin
    if (cmd.action == act_load_instr) begin
      imem[cmd.index] <= pio_instr_t'(cmd.data[15:0]);
    end
  end

  always_comb begin
    is_exec = (cmd.action == act_exec);
    do_step = is_exec || enabled;
    // Exec word wins over the fetched instruction
    instr = is_exec ? pio_instr_t'(cmd.data[15:0]) : imem[pc];
    // Pins base .. base + count - 1
    set_mask = ((num_pins'(1) << set_count) - 1'b1) << set_base;
    set_bits = num_pins'(instr.set_f.data) << set_base;
  end

  always_ff @(posedge clk_25mhz) begin
    if (!pwr_up_reset_n) begin
      pc <= '0;
      enabled <= 1'b0;
      set_base <= '0;
      set_count <= '0;
      gpio_out <= '0;
      gpio_dir <= '0;
    end else begin
      // Configuration commands
      case (cmd.action)
        act_set_pinctrl: begin
          set_base <= cmd.data[4:0];
          set_count <= cmd.data[7:5];
        end
        act_enable: enabled <= cmd.data[0];
        default: ;
      endcase

      if (do_step) begin
        case (instr.jmp_f.opcode)
          op_jmp: pc <= instr.jmp_f.addr;  // Unconditional
          op_set: begin
            if (!is_exec) begin
              pc <= pc + 1'b1;
            end
            if (instr.set_f.dest == dest_pins) begin
              gpio_out <= (gpio_out & ~set_mask) | (set_bits & set_mask);
            end else if (instr.set_f.dest == dest_pindirs) begin
              gpio_dir <= (gpio_dir & ~set_mask) | (set_bits & set_mask);
            end
          end
          default: begin
            // Unsupported opcode just moves on
            if (!is_exec) begin
              pc <= pc + 1'b1;
            end
          end
        endcase
      end

      // Enable always restarts the program at address 0
      if (cmd.action == act_enable) begin
        pc <= '0;
      end
    end
  end

endmodule

/* src/blinky_pio_top.sv */
`timescale 1ns/1ps

module blinky_pio_top #(
  parameter int period_log2 = pio_ctrl_pkg::blink_period_log2
) (
  input  logic        clk_25mhz,
  input  logic        pwr_up_reset_n,
  output logic [7:0]  led,
  output logic [27:0] gn
);
  import pio_ctrl_pkg::*;
  import pio_isa_pkg::*;

  pio_cmd_t            cmd;       // Loader to core
  logic                run;
  logic                tick;
  logic [num_pins-1:0] gpio_out;
  logic [num_pins-1:0] gpio_dir;

  pio_loader_fsm u_loader (
    .clk_25mhz      (clk_25mhz),
    .pwr_up_reset_n (pwr_up_reset_n),
    .tick           (tick),
    .run            (run),
    .cmd            (cmd)
  );

  blink_timer #(
    .period_log2 (period_log2)
  ) u_timer (
    .clk_25mhz      (clk_25mhz),
    .pwr_up_reset_n (pwr_up_reset_n),
    .run            (run),
    .tick           (tick)
  );

  pio_core u_core (
    .clk_25mhz      (clk_25mhz),
    .pwr_up_reset_n (pwr_up_reset_n),
    .cmd            (cmd),
    .gpio_out       (gpio_out),
    .gpio_dir       (gpio_dir)
  );

  assign led = gpio_out[7:0];
  assign gn = gpio_dir[27:0];  // Directions shown on the header pins

endmodule

/* sim/tb_blinky_pio.sv */
`timescale 1ns/1ps

module tb_blinky_pio;

  localparam int clk_period   = 40;
  localparam int drive_delay  = 2;    // Inputs change this long after the rising edge
  localparam int reset_cycles = 8;
  localparam int num_patterns = 28;
  localparam int run_start    = 35;   // First cycle with run high
  localparam int reset_window = 48;   // Run cycles past the last pattern
  localparam int wd_margin    = 100;

  logic        clk_25mhz;
  logic        pwr_up_reset_n;
  logic [7:0]  led;
  logic [27:0] gn;

  logic [31:0] pat_mem [3*num_patterns];  // Offset, led, gn per pattern
  logic [31:0] rnd_state;
  int          last_offset;
  int          reset_cycle;
  int          span;
  int          watchdog_cycles;

  blinky_pio_top #(
    .period_log2 (4)
  ) UUT (
    .clk_25mhz      (clk_25mhz),
    .pwr_up_reset_n (pwr_up_reset_n),
    .led            (led),
    .gn             (gn)
  );

  initial begin
    clk_25mhz = 1'b0;
    forever #(clk_period / 2) clk_25mhz = ~clk_25mhz;
  end

  function automatic logic [31:0] next_random(input logic [31:0] state);
    logic [31:0] x;
    begin
      x = state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
    end
  endfunction

  task automatic stop_with_failure();
    begin
      $display("*** FAILED ***");
      $fatal(1, "Simulation stopped at the first error");
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    begin
      if (actual !== expected) begin
        $display("ERR %s actual 0x%0h expected 0x%0h at %0t", name, actual, expected,
                 $time);
        stop_with_failure();
      end
    end
  endtask

  // Reset is already low on entry and goes high after reset_cycles edges
  task automatic hold_reset();
    int i;
    begin
      for (i = 0; i < reset_cycles; i++) begin
        @(posedge clk_25mhz);
        #(drive_delay);
        if (i == reset_cycles - 1) begin
          pwr_up_reset_n = 1'b1;
        end
        @(negedge clk_25mhz);
        check_value("led", 32'(led), 32'h0);
        check_value("gn", 32'(gn), 32'h0);
      end
    end
  endtask

  // Cycle 0 is the first edge with reset high and each cycle is sampled at the falling edge
  task automatic replay_patterns(input int stop_cycle);
    int cycle;
    int p;
    begin
      p = 0;
      for (cycle = 0; cycle <= stop_cycle; cycle++) begin
        @(posedge clk_25mhz);
        @(negedge clk_25mhz);
        // Set count of 1 keeps everything on pin 0
        check_value("led[7:1]", 32'(led[7:1]), 32'h0);
        check_value("gn[27:1]", 32'(gn[27:1]), 32'h0);
        if (p < num_patterns && pat_mem[3*p] == 32'(cycle)) begin
          check_value("led", 32'(led), pat_mem[3*p+1]);
          check_value("gn", 32'(gn), pat_mem[3*p+2]);
          p++;
        end
      end
      if (stop_cycle >= last_offset && p != num_patterns) begin
        $display("Pattern offsets are not ascending, only %0d of %0d patterns were checked",
                 p, num_patterns);
        stop_with_failure();
      end
    end
  endtask

  initial begin
    wait (watchdog_cycles > 0);
    repeat (watchdog_cycles) @(posedge clk_25mhz);
    $display("Watchdog timeout, the pattern replay did not finish within %0d cycles",
             watchdog_cycles);
    stop_with_failure();
  end

  initial begin
    pwr_up_reset_n = 1'b0;
    $readmemh("sim/blink_patterns.mem", pat_mem);
    last_offset = int'(pat_mem[3*(num_patterns-1)]);

    // Reset lands somewhere in run state and possibly mid pattern list
    rnd_state = 32'h35d61d3c;
    rnd_state = next_random(rnd_state);
    span = last_offset + reset_window - run_start + 1;
    reset_cycle = run_start + int'(rnd_state % 32'(span));
    watchdog_cycles = 2 * (reset_cycles + 1) + reset_cycle + last_offset + 2 + wd_margin;
    $display("Mid-run reset after cycle %0d", reset_cycle);

    hold_reset();
    replay_patterns(reset_cycle);

    @(posedge clk_25mhz);
    #(drive_delay);
    pwr_up_reset_n = 1'b0;
    hold_reset();
    replay_patterns(last_offset);  // Whole list again from offset 0

    $display("*** PASSED ***");
    $finish;
  end

endmodule

/* sim/blink_patterns.mem */
// Columns: cycle offset after reset release, expected led, expected gn (all hex)
// Values are sampled at the falling edge inside the given cycle
0000 00 0000000
0001 00 0000000
0010 00 0000000
001f 00 0000000
0020 00 0000000
0021 00 0000000
0022 00 0000000
0023 00 0000001
0024 00 0000001
0025 01 0000001
0026 01 0000001
002c 01 0000001
0034 01 0000001
0035 00 0000001
0036 00 0000001
003c 00 0000001
0044 00 0000001
0045 01 0000001
0046 01 0000001
0054 01 0000001
0055 00 0000001
0056 00 0000001
0064 00 0000001
0065 01 0000001
0066 01 0000001
006e 01 0000001
0074 01 0000001
0075 00 0000001

/* blink.mem */
// Program image: SET pindirs 1, then JMP 1 forever
e081
0001
0000
0000
0000
0000
0000
0000
0000
0000
0000
0000
0000
0000
0000
0000
0000
0000
0000
0000
0000
0000
0000
0000
0000
0000
0000
0000
0000
0000
0000
0000

/* exec_conf.mem */
// Columns: action code (top hex digit), 32-bit data word
// Pin control base 0 count 1, enable, then no action
500000020
600000001
000000000

/* list.f */
src/pio_ctrl_pkg.sv
src/pio_isa_pkg.sv
src/pio_loader_fsm.sv
src/blink_timer.sv
src/pio_core.sv
src/blinky_pio_top.sv
sim/tb_blinky_pio.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= tb_blinky_pio
FILE_LIST  ?= list.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
PASS_TEXT  ?= *** PASSED ***
VFLAGS     ?= --binary --timing
LINT_FLAGS ?= --lint-only --timing

SRCS := $(wildcard src/*.sv sim/*.sv)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

$(OBJ_DIR)/V$(TOP): $(FILE_LIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

sim: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qF '$(PASS_TEXT)' $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
